// ==== list.f ====
verilog/bfly_pkg.sv
verilog/frame_writer.sv
verilog/pair_reader.sv
verilog/sample_ram.sv
verilog/butterfly.sv
verilog/bfly_stage_top.sv
sim/bfly_stage_tb.sv

// ==== sim/bfly_stage_tb.sv ====
`timescale 1ns/1ps

module bfly_stage_tb
    import bfly_pkg::*;
();

    localparam int frame_len = 16;
    localparam int half = frame_len / 2;
    localparam int num_frames = 7;
    localparam int watchdog_cycles = num_frames * 3 * frame_len + 200;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    cplx_t     in_sample;
    logic      out_valid;
    bfly_out_t out_result;
    logic      frame_done;

    // Every frame as it was sent.
    cplx_t sent [num_frames][frame_len];
    int    frames_sent;

    bfly_out_t   got_q [$];
    int          out_cycles [$];
    int          in_cycles [$];
    int          done_count = 0;
    int          cycle_cnt = 0;
    logic [15:0] lfsr_state;

    bfly_stage_top #(.frame_len(frame_len)) bfly_stage_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_result (out_result),
        .frame_done (frame_done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Outputs are sampled half a cycle after the driving edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid) begin
                in_cycles.push_back(cycle_cnt);
            end
            if (out_valid) begin
                got_q.push_back(out_result);
                out_cycles.push_back(cycle_cnt);
            end
            if (frame_done) begin
                done_count++;
            end
        end
    end

    // Taps 16, 14, 13, 11.
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        logic        fb;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[5];
            lfsr_state = {fb, lfsr_state[15:1]};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR time %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic clear_monitor();
        got_q.delete();
        out_cycles.delete();
        in_cycles.delete();
        done_count = 0;
    endtask

    task automatic fill_ramp(input int idx);
        int n;
        for (n = 0; n < frame_len; n++) begin
            sent[idx][n].re = sample_t'(n);
            sent[idx][n].im = sample_t'(-n);
        end
    endtask

    task automatic fill_random(input int idx);
        int n;
        for (n = 0; n < frame_len; n++) begin
            sent[idx][n].re = sample_t'(next_bits(16));
            sent[idx][n].im = sample_t'(next_bits(16));
        end
    endtask

    task automatic send_frame(input int idx, input int max_gap);
        int n;
        int gap;
        for (n = 0; n < frame_len; n++) begin
            @(posedge clk);
            in_valid  <= 1'b1;
            in_sample <= sent[idx][n];
            gap = (max_gap > 0) ? int'(next_bits(2)) : 0;
            if (gap > 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
    endtask

    task automatic end_input();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_outputs(input int count);
        int waited;
        waited = 0;
        while (got_q.size() < count && waited < 4 * frame_len) begin
            @(posedge clk);
            waited++;
        end
        if (got_q.size() < count) begin
            abort_run($sformatf("Missing outputs: only %0d of %0d results arrived",
                                got_q.size(), count));
        end
        // Nothing extra may follow.
        repeat (frame_len) @(posedge clk);
        check_equal("number of outputs", got_q.size(), count);
    endtask

    task automatic check_frames(input int first, input int count);
        int        f;
        int        k;
        int        i;
        bfly_out_t r;
        cplx_t     a;
        cplx_t     b;
        wait_outputs(count * half);
        for (f = 0; f < count; f++) begin
            for (k = 0; k < half; k++) begin
                i = f * half + k;
                r = got_q[i];
                a = sent[first + f][k];
                b = sent[first + f][k + half];
                check_equal($sformatf("frame %0d k %0d sum_re", first + f, k),
                            int'(r.sum_re), int'(a.re) + int'(b.re));
                check_equal($sformatf("frame %0d k %0d sum_im", first + f, k),
                            int'(r.sum_im), int'(a.im) + int'(b.im));
                check_equal($sformatf("frame %0d k %0d dif_re", first + f, k),
                            int'(r.dif_re), int'(a.re) - int'(b.re));
                check_equal($sformatf("frame %0d k %0d dif_im", first + f, k),
                            int'(r.dif_im), int'(a.im) - int'(b.im));
                if (k > 0) begin
                    check_equal("output spacing", out_cycles[i] - out_cycles[i - 1], 2);
                end
            end
        end
        check_equal("frame_done pulses", done_count, count);
    endtask

    task automatic test_reset_state();
        clear_monitor();
        repeat (20) begin
            @(negedge clk);
            check_equal("out_valid while idle", int'(out_valid), 0);
            check_equal("frame_done while idle", int'(frame_done), 0);
        end
    endtask

    task automatic test_ramp();
        int idx;
        clear_monitor();
        idx = frames_sent;
        frames_sent++;
        fill_ramp(idx);
        send_frame(idx, 0);
        end_input();
        check_frames(idx, 1);
    endtask

    // Extreme values push the result to the ends of the 17-bit range.
    task automatic test_random_corners();
        int idx;
        clear_monitor();
        idx = frames_sent;
        frames_sent++;
        fill_random(idx);
        sent[idx][0]  = {16'sh7fff, 16'sh7fff};
        sent[idx][8]  = {16'sh7fff, 16'sh7fff};
        sent[idx][1]  = {16'sh8000, 16'sh8000};
        sent[idx][9]  = {16'sh8000, 16'sh8000};
        sent[idx][2]  = {16'sh7fff, 16'sh8000};
        sent[idx][10] = {16'sh8000, 16'sh7fff};
        send_frame(idx, 0);
        end_input();
        check_frames(idx, 1);
    endtask

    task automatic test_back_to_back();
        int first;
        int f;
        clear_monitor();
        first = frames_sent;
        for (f = 0; f < 3; f++) begin
            fill_random(frames_sent);
            send_frame(frames_sent, 0);
            frames_sent++;
        end
        end_input();
        check_frames(first, 3);
    endtask

    task automatic test_gapped();
        int first;
        int f;
        clear_monitor();
        first = frames_sent;
        for (f = 0; f < 2; f++) begin
            fill_random(frames_sent);
            send_frame(frames_sent, 3);
            frames_sent++;
        end
        end_input();
        check_frames(first, 2);
        // frame_full follows the last strobe by one cycle, the output by four more.
        for (f = 0; f < 2; f++) begin
            check_equal($sformatf("latency of frame %0d", first + f),
                        out_cycles[f * half] - in_cycles[(f + 1) * frame_len - 1], 5);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("Timeout: the tests did not finish within the time limit");
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_sample   = '0;
        lfsr_state  = 16'd50584;
        frames_sent = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_reset_state();
        test_ramp();
        test_random_corners();
        test_back_to_back();
        test_gapped();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog/bfly_pkg.sv ====
package bfly_pkg;

    // Width of one real or imaginary component at the input.
    localparam int sample_w = 16;

    typedef logic signed [sample_w-1:0] sample_t;

    // One bit of growth for the sum and the difference.
    typedef logic signed [sample_w:0] wide_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // a is element k, b is element k + frame_len/2.
    typedef struct packed {
        cplx_t a;
        cplx_t b;
    } cplx_pair_t;

    typedef struct packed {
        wide_t sum_re;
        wide_t sum_im;
        wide_t dif_re;
        wide_t dif_im;
    } bfly_out_t;

    // Marks whether the next read is the first or the second of a pair.
    typedef enum logic {
        first_out,
        sec_out
    } rd_state_t;

endpackage

// ==== verilog/bfly_stage_top.sv ====
`timescale 1ns/1ps

module bfly_stage_top
    import bfly_pkg::*;
#(
    parameter int frame_len = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  cplx_t     in_sample,
    output logic      out_valid,
    output bfly_out_t out_result,
    output logic      frame_done
);

    localparam int addr_w = $clog2(frame_len) + 1;

    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    cplx_t             wr_sample;
    logic              frame_full;
    logic              full_bank;
    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    logic              pair_valid;
    cplx_pair_t        pair;

    frame_writer #(.frame_len(frame_len)) frame_writer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_sample  (wr_sample),
        .frame_full (frame_full),
        .full_bank  (full_bank)
    );

    pair_reader #(.frame_len(frame_len)) pair_reader_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_full (frame_full),
        .full_bank  (full_bank),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .frame_done (frame_done)
    );

    sample_ram #(.frame_len(frame_len)) sample_ram_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_sample  (wr_sample),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    butterfly butterfly_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair_valid (pair_valid),
        .pair       (pair),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

// ==== verilog/butterfly.sv ====
`timescale 1ns/1ps

module butterfly
    import bfly_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pair_valid,
    input  cplx_pair_t pair,
    output logic       out_valid,
    output bfly_out_t  out_result
);

    wide_t a_re;
    wide_t a_im;
    wide_t b_re;
    wide_t b_im;

    // Sign extension to the result width.
    assign a_re = wide_t'(pair.a.re);
    assign a_im = wide_t'(pair.a.im);
    assign b_re = wide_t'(pair.b.re);
    assign b_im = wide_t'(pair.b.im);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pair_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pair_valid) begin
            out_result.sum_re <= a_re + b_re;
            out_result.sum_im <= a_im + b_im;
            out_result.dif_re <= a_re - b_re;
            out_result.dif_im <= a_im - b_im;
        end
    end

    // Pairs come at most every second cycle.
    a_pair_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        pair_valid |=> !pair_valid
    ) else $error("butterfly: pair_valid high in consecutive cycles");

endmodule

// ==== verilog/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer
    import bfly_pkg::*;
#(
    parameter int frame_len = 16,
    localparam int cnt_w = $clog2(frame_len),
    localparam int addr_w = cnt_w + 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  cplx_t             in_sample,
    output logic              wr_en,
    output logic [addr_w-1:0] wr_addr,
    output cplx_t             wr_sample,
    output logic              frame_full,
    output logic              full_bank
);

    logic [cnt_w-1:0] count;
    logic             bank;
    logic             last_sample;

    assign last_sample = (count == cnt_w'(frame_len - 1));

    // The sample is written in the cycle of its strobe.
    assign wr_en     = in_valid;
    assign wr_addr   = {bank, count};
    assign wr_sample = in_sample;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count      <= '0;
            bank       <= 1'b0;
            frame_full <= 1'b0;
            full_bank  <= 1'b0;
        end else begin
            frame_full <= 1'b0;
            if (in_valid) begin
                count <= count + 1'b1;
                if (last_sample) begin
                    // Count wraps to zero on its own.
                    frame_full <= 1'b1;
                    full_bank  <= bank;
                    bank       <= ~bank;
                end
            end
        end
    end

endmodule

// ==== verilog/pair_reader.sv ====
`timescale 1ns/1ps

module pair_reader
    import bfly_pkg::*;
#(
    parameter int frame_len = 16,
    localparam int step_w = $clog2(frame_len),
    localparam int addr_w = step_w + 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frame_full,
    input  logic              full_bank,
    output logic              rd_en,
    output logic [addr_w-1:0] rd_addr,
    output logic              frame_done
);

    logic              busy;
    logic [step_w-1:0] step;
    logic              bank;
    logic              last_step;

    assign last_step = (step == step_w'(frame_len - 1));

    assign rd_en      = busy;
    assign frame_done = busy && last_step;

    // Step s reads k = s/2, plus half a frame when s is odd.
    // Half a frame is the top offset bit, so this is a rotate of the step.
    assign rd_addr = {bank, step[0], step[step_w-1:1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
            bank <= 1'b0;
        end else if (frame_full) begin
            // A new frame may start right on the final step.
            busy <= 1'b1;
            step <= '0;
            bank <= full_bank;
        end else if (busy) begin
            step <= step + 1'b1;
            if (last_step) begin
                busy <= 1'b0;
            end
        end
    end

    // Input must not outrun the reader.
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_full |-> (!busy || last_step)
    ) else $error("pair_reader: frame_full while previous frame still being read");

endmodule

// ==== verilog/sample_ram.sv ====
`timescale 1ns/1ps

module sample_ram
    import bfly_pkg::*;
#(
    parameter int frame_len = 16,
    localparam int addr_w = $clog2(frame_len) + 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  cplx_t             wr_sample,
    input  logic              rd_en,
    input  logic [addr_w-1:0] rd_addr,
    output logic              pair_valid,
    output cplx_pair_t        pair
);

    localparam int depth = 2 * frame_len;

    // Two banks, the bank bit is the top address bit.
    cplx_t mem [depth];

    cplx_t rd_data;
    cplx_t hold_data;

    rd_state_t state;
    logic      hold_en;
    logic      pair_rdy;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
        if (wr_en) begin
            mem[wr_addr] <= wr_sample;
        end
    end

    // Pairing FSM.
    // The first read raises hold_en, the second raises pair_rdy.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= first_out;
            hold_en  <= 1'b0;
            pair_rdy <= 1'b0;
        end else begin
            case (state)
                first_out: begin
                    pair_rdy <= 1'b0;
                    if (rd_en) begin
                        state   <= sec_out;
                        hold_en <= 1'b1;
                    end else begin
                        hold_en <= 1'b0;
                    end
                end
                sec_out: begin
                    state    <= first_out;
                    hold_en  <= 1'b0;
                    pair_rdy <= 1'b1;
                end
                default: begin
                    state    <= first_out;
                    hold_en  <= 1'b0;
                    pair_rdy <= 1'b0;
                end
            endcase
        end
    end

    // First word of the pair waits here for the second.
    always_ff @(posedge clk) begin
        if (hold_en) begin
            hold_data <= rd_data;
        end
    end

    assign pair_valid = pair_rdy;
    assign pair.a     = hold_data;
    assign pair.b     = rd_data;

    // Writer and reader must be on different banks.
    a_no_addr_clash: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en && rd_en) |-> (wr_addr != rd_addr)
    ) else $error("sample_ram: write and read hit the same address");

endmodule
